// ==== hw/scaler_consts.svh ====
`ifndef SCALER_CONSTS_SVH
`define SCALER_CONSTS_SVH

`default_nettype none

// sizing shared by both banks, the readout and the testbench

// beams on the front end, two threshold bits each
`define SCAL_NBEAMS 6

// one scaler, saturates at all ones
`define SCAL_CNT_W 16

// host read address
`define SCAL_ADR_W 7

// status word sits at the top of the address space
`define SCAL_STATUS_ADR 7'd127

// count addresses run from 0 to 2*nbeams-1
`define SCAL_NCOUNT_ADR (2 * `SCAL_NBEAMS)

`default_nettype wire

`endif

// ==== hw/scaler_pkg.sv ====
`include "scaler_consts.svh"

`default_nettype none

package scaler_pkg;

    // one 32-bit read word, decoded per address
    typedef union packed {
        struct packed {
            logic [15:0] rsvd;          // reads zero
            logic [15:0] count;
        } count_view;
        struct packed {
            logic [15:0] period;        // completed periods
            logic [7:0]  nbeams;
            logic [6:0]  rsvd;          // reads zero
            logic        valid;         // set after the first timer pulse
        } status_view;
    } scal_word_u;

    // add one sampled bit, stick at all ones
    function automatic logic [`SCAL_CNT_W-1:0] sat_inc(
        input logic [`SCAL_CNT_W-1:0] cnt,
        input logic                   inc
    );
        logic [`SCAL_CNT_W:0] sum;
        sum = {1'b0, cnt} + {{`SCAL_CNT_W{1'b0}}, inc};
        return sum[`SCAL_CNT_W] ? {`SCAL_CNT_W{1'b1}} : sum[`SCAL_CNT_W-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== hw/beam_scaler_bank.sv ====
`include "scaler_consts.svh"

`default_nettype none

// one bank of cycle counters, one per beam, for a single threshold level
module beam_scaler_bank import scaler_pkg::*; (
    input  logic                                  ifclk,
    input  logic                                  rst_n_i,
    input  logic [`SCAL_NBEAMS-1:0]               hit_i,      // discriminator bits
    input  logic                                  timer_i,    // end of period
    output logic [`SCAL_NBEAMS*`SCAL_CNT_W-1:0]   held_o      // beam b at [b*W +: W]
);

    for (genvar b = 0; b < `SCAL_NBEAMS; b++) begin : g_beam

        logic [`SCAL_CNT_W-1:0] run_q;    // running count of this period
        logic [`SCAL_CNT_W-1:0] held_q;   // count of the last closed period
        logic [`SCAL_CNT_W-1:0] run_nxt;

        // the sample taken on the timer edge still belongs to the closing period
        assign run_nxt = sat_inc(run_q, hit_i[b]);

        always_ff @(posedge ifclk) begin
            if (!rst_n_i) begin
                run_q <= '0;
            end else if (timer_i) begin
                run_q <= '0;              // restart for the next period
            end else begin
                run_q <= run_nxt;
            end
        end

        // host reads zero until the first period closes
        always_ff @(posedge ifclk) begin
            if (!rst_n_i) begin
                held_q <= '0;
            end else if (timer_i) begin
                held_q <= run_nxt;
            end
        end

        assign held_o[b*`SCAL_CNT_W +: `SCAL_CNT_W] = held_q;

    end

endmodule

`default_nettype wire

// ==== hw/scaler_readout.sv ====
`include "scaler_consts.svh"

`default_nettype none

// period bookkeeping and the host read port over both scaler banks
module scaler_readout import scaler_pkg::*; (
    input  logic                                  ifclk,
    input  logic                                  rst_n_i,
    input  logic                                  timer_i,
    input  logic [`SCAL_NBEAMS*`SCAL_CNT_W-1:0]   lo_held_i,
    input  logic [`SCAL_NBEAMS*`SCAL_CNT_W-1:0]   hi_held_i,
    input  logic                                  rd_req_i,
    input  logic [`SCAL_ADR_W-1:0]                rd_adr_i,
    output logic                                  rd_ack_o,
    output logic [$bits(scal_word_u)-1:0]         rd_dat_o,
    output logic                                  done_o
);

    // read FSM encoding
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_DECODE  = 2'd1;
    localparam logic [1:0] ST_ACK     = 2'd2;
    localparam logic [1:0] ST_RELEASE = 2'd3;

    logic [15:0]                 period_q;    // completed periods
    logic                        valid_q;
    logic                        done_q;

    logic [1:0]                  state_q;
    logic                        ack_q;
    logic [`SCAL_ADR_W-1:0]      adr_q;       // address captured with the request
    logic [`SCAL_ADR_W-2:0]      beam_idx;
    logic [`SCAL_CNT_W-1:0]      sel_cnt;
    scal_word_u                  word;        // word built from adr_q
    logic [$bits(scal_word_u)-1:0] dat_q;

    // period counter and valid flag, both move on the snapshot
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            period_q <= '0;
            valid_q  <= 1'b0;
        end else if (timer_i) begin
            period_q <= period_q + 16'd1;
            valid_q  <= 1'b1;
        end
    end

    // held counts are loaded on the timer edge, so done follows one cycle later
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= timer_i;
        end
    end

    assign done_o = done_q;

    // address decode
    assign beam_idx = adr_q[`SCAL_ADR_W-1:1];   // even = low, odd = high
    assign sel_cnt  = adr_q[0] ? hi_held_i[beam_idx*`SCAL_CNT_W +: `SCAL_CNT_W]
                               : lo_held_i[beam_idx*`SCAL_CNT_W +: `SCAL_CNT_W];

    always_comb begin
        word = '0;                              // unused addresses read zero
        if (adr_q == `SCAL_STATUS_ADR) begin
            word.status_view.period = period_q;
            word.status_view.nbeams = 8'(`SCAL_NBEAMS);
            word.status_view.valid  = valid_q;
        end else if (adr_q < `SCAL_NCOUNT_ADR) begin
            word.count_view.count = sel_cnt;
        end
    end

    // four-phase read handshake
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (rd_req_i) begin
                        state_q <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    state_q <= ST_ACK;          // word lands on rd_dat_o here
                end
                ST_ACK: begin
                    ack_q <= 1'b1;
                    // wait for the host to drop its request
                    if (ack_q && !rd_req_i) begin
                        state_q <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    ack_q   <= 1'b0;
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                    ack_q   <= 1'b0;
                end
            endcase
        end
    end

    // address and data registers carry no reset
    always_ff @(posedge ifclk) begin
        if (state_q == ST_IDLE && rd_req_i) begin
            adr_q <= rd_adr_i;
        end
        // latched once, a later snapshot leaves it alone
        if (state_q == ST_DECODE) begin
            dat_q <= word;
        end
    end

    assign rd_ack_o = ack_q;
    assign rd_dat_o = dat_q;

endmodule

`default_nettype wire

// ==== hw/beamscaler_top.sv ====
`include "scaler_consts.svh"

`default_nettype none

// beam scaler, low and high threshold banks plus the host readout
module beamscaler_top import scaler_pkg::*; (
    input  logic                          ifclk,
    input  logic                          rst_n_i,
    input  logic [2*`SCAL_NBEAMS-1:0]     count_i,    // {hi, lo} per beam
    input  logic                          timer_i,
    output logic                          done_o,
    input  logic                          rd_req_i,
    input  logic [`SCAL_ADR_W-1:0]        rd_adr_i,
    output logic                          rd_ack_o,
    output logic [$bits(scal_word_u)-1:0] rd_dat_o
);

    logic [`SCAL_NBEAMS-1:0]              lo_hit;
    logic [`SCAL_NBEAMS-1:0]              hi_hit;
    logic [`SCAL_NBEAMS*`SCAL_CNT_W-1:0]  lo_held;
    logic [`SCAL_NBEAMS*`SCAL_CNT_W-1:0]  hi_held;

    // even bits are the low thresholds, odd bits the high ones
    for (genvar b = 0; b < `SCAL_NBEAMS; b++) begin : g_split
        assign lo_hit[b] = count_i[2*b];
        assign hi_hit[b] = count_i[2*b+1];
    end

    beam_scaler_bank u_lo_bank (
        .ifclk   (ifclk),
        .rst_n_i (rst_n_i),
        .hit_i   (lo_hit),
        .timer_i (timer_i),
        .held_o  (lo_held)
    );

    beam_scaler_bank u_hi_bank (
        .ifclk   (ifclk),
        .rst_n_i (rst_n_i),
        .hit_i   (hi_hit),
        .timer_i (timer_i),
        .held_o  (hi_held)
    );

    scaler_readout u_readout (
        .ifclk     (ifclk),
        .rst_n_i   (rst_n_i),
        .timer_i   (timer_i),
        .lo_held_i (lo_held),
        .hi_held_i (hi_held),
        .rd_req_i  (rd_req_i),
        .rd_adr_i  (rd_adr_i),
        .rd_ack_o  (rd_ack_o),
        .rd_dat_o  (rd_dat_o),
        .done_o    (done_o)
    );

endmodule

`default_nettype wire

// ==== dv/beamscaler_tb.sv ====
`include "scaler_consts.svh"

`default_nettype none

// testbench for the beam scaler that drives count_i and timer_i and reads back over req/ack
module beamscaler_tb import scaler_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCNT           = 2 * `SCAL_NBEAMS;   // count addresses
    localparam int SAT_BIT        = 5;                  // high threshold of beam 2
    localparam int SAT_CYCLES     = 65600;              // beyond the 16-bit range

    // saturation period is about 66k cycles, everything else stays under 6k
    localparam int TIMEOUT_CYCLES = 80000;

    logic                         ifclk = 1'b0;
    logic                         rst_n_i;
    logic [2*`SCAL_NBEAMS-1:0]    count_i;
    logic                         timer_i;
    logic                         done_o;
    logic                         rd_req_i;
    logic [`SCAL_ADR_W-1:0]       rd_adr_i;
    logic                         rd_ack_o;
    logic [31:0]                  rd_dat_o;

    // reference model indexed by count_i bit, which is also the read address
    logic [`SCAL_CNT_W-1:0]       m_run  [NCNT];
    logic [`SCAL_CNT_W-1:0]       m_held [NCNT];
    logic [15:0]                  m_periods;
    logic                         m_valid;

    int                           errors = 0;
    int                           checks = 0;
    int                           tests_run = 0;
    int                           tests_bad = 0;
    int                           errors_at_start = 0;
    int                           cycle_cnt;

    beamscaler_top uut (
        .ifclk    (ifclk),
        .rst_n_i  (rst_n_i),
        .count_i  (count_i),
        .timer_i  (timer_i),
        .done_o   (done_o),
        .rd_req_i (rd_req_i),
        .rd_adr_i (rd_adr_i),
        .rd_ack_o (rd_ack_o),
        .rd_dat_o (rd_dat_o)
    );

    always #2 ifclk = ~ifclk;   // 4 ns period

    // one more high cycle, but never past all ones
    function automatic logic [`SCAL_CNT_W-1:0] add_hit(
        input logic [`SCAL_CNT_W-1:0] cnt,
        input logic                   hit
    );
        if (hit && cnt != {`SCAL_CNT_W{1'b1}}) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    function automatic logic [2*`SCAL_NBEAMS-1:0] rand_bits();
        logic [31:0] r;
        r = $urandom;
        return r[2*`SCAL_NBEAMS-1:0];
    endfunction

    // count rule applied to what the stimulus drives
    always @(posedge ifclk) begin : ref_model
        logic [`SCAL_CNT_W-1:0] nxt;
        if (!rst_n_i) begin
            for (int i = 0; i < NCNT; i++) begin
                m_run[i]  = '0;
                m_held[i] = '0;
            end
            m_periods = '0;
            m_valid   = 1'b0;
        end else begin
            for (int i = 0; i < NCNT; i++) begin
                nxt = add_hit(m_run[i], count_i[i]);
                if (timer_i) begin
                    m_held[i] = nxt;    // timer edge sample closes the period
                    m_run[i]  = '0;
                end else begin
                    m_run[i] = nxt;
                end
            end
            if (timer_i) begin
                m_periods = m_periods + 16'd1;
                m_valid   = 1'b1;
            end
        end
    end

    task automatic protocol_error(input string what);
        errors++;
        $display("protocol error at %0t ns: %s", $time, what);
    endtask

    // handshake and done_o timing
    a_ack_needs_req: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        $rose(rd_ack_o) |-> $past(rd_req_i) && $past(rd_req_i, 3))
        else protocol_error("rd_ack_o rose without a held request");

    a_ack_rise: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        $past(rd_req_i, 3) && !$past(rd_req_i, 4) |-> $rose(rd_ack_o))
        else protocol_error("rd_ack_o did not rise 2 cycles after the request");

    a_ack_hold: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        rd_ack_o && rd_req_i |=> rd_ack_o)
        else protocol_error("rd_ack_o dropped while the request was still held");

    a_ack_fall: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        $fell(rd_ack_o) |-> !$past(rd_req_i, 1) && !$past(rd_req_i, 2) && $past(rd_req_i, 3))
        else protocol_error("rd_ack_o fell at the wrong time after the request dropped");

    a_ack_drop: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        $past(rd_ack_o, 2) && $past(rd_req_i, 3) && !$past(rd_req_i, 2) |-> $fell(rd_ack_o))
        else protocol_error("rd_ack_o did not fall 1 cycle after the request dropped");

    a_dat_stable: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        rd_ack_o |-> $stable(rd_dat_o))
        else protocol_error("rd_dat_o changed while rd_ack_o was high");

    a_done_lat: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        done_o == $past(timer_i))
        else protocol_error("done_o does not follow timer_i by one cycle");

    a_done_pulse: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        done_o |=> !done_o)
        else protocol_error("done_o stayed high for more than one cycle");

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drive_random(input int ncycles);
        repeat (ncycles) begin
            @(negedge ifclk);
            count_i = rand_bits();
        end
    endtask

    // one input stuck high, the rest random
    task automatic hold_bit(input int bit_idx, input int ncycles);
        logic [2*`SCAL_NBEAMS-1:0] v;
        repeat (ncycles) begin
            @(negedge ifclk);
            v          = rand_bits();
            v[bit_idx] = 1'b1;
            count_i    = v;
        end
    endtask

    task automatic pulse_timer();
        int waited;
        @(negedge ifclk);
        timer_i = 1'b1;
        count_i = rand_bits();      // sampled on the timer edge as well
        @(negedge ifclk);
        timer_i = 1'b0;
        count_i = '0;
        waited  = 0;
        while (!done_o && waited < 4) begin
            @(negedge ifclk);
            waited++;
        end
        if (!done_o) begin
            errors++;
            $display("done_o never pulsed after the timer pulse at %0t ns", $time);
        end
    endtask

    task automatic read_open(input int adr, output logic [31:0] word);
        int waited;
        @(negedge ifclk);
        rd_adr_i = adr[`SCAL_ADR_W-1:0];
        rd_req_i = 1'b1;
        waited   = 0;
        while (!rd_ack_o && waited < 16) begin
            @(negedge ifclk);
            waited++;
        end
        if (!rd_ack_o) begin
            errors++;
            $display("read of address %0d was never acknowledged", adr);
        end
        word = rd_dat_o;
    endtask

    task automatic read_close(input int hold);
        int waited;
        repeat (hold) @(negedge ifclk);     // host back-pressure
        rd_req_i = 1'b0;
        waited   = 0;
        while (rd_ack_o && waited < 16) begin
            @(negedge ifclk);
            waited++;
        end
        if (rd_ack_o) begin
            errors++;
            $display("rd_ack_o stayed high after the request dropped");
        end
    endtask

    task automatic host_read(input int adr, output logic [31:0] word);
        read_open(adr, word);
        read_close($urandom_range(0, 5));
    endtask

    task automatic check_count(input int adr, input logic [`SCAL_CNT_W-1:0] exp);
        logic [31:0] raw;
        scal_word_u  w;
        host_read(adr, raw);
        w = raw;
        check_value($sformatf("rd_dat_o.count (adr %0d)", adr),
                    {16'h0, w.count_view.count}, {16'h0, exp});
        check_value($sformatf("rd_dat_o.rsvd (adr %0d)", adr),
                    {16'h0, w.count_view.rsvd}, 32'h0);
    endtask

    task automatic check_all_counts();
        for (int a = 0; a < NCNT; a++) begin
            check_count(a, m_held[a]);
        end
    endtask

    task automatic check_status(input logic [15:0] period, input logic valid);
        logic [31:0] raw;
        scal_word_u  w;
        host_read(`SCAL_STATUS_ADR, raw);
        w = raw;
        check_value("rd_dat_o.period", {16'h0, w.status_view.period}, {16'h0, period});
        check_value("rd_dat_o.nbeams", {24'h0, w.status_view.nbeams}, `SCAL_NBEAMS);
        check_value("rd_dat_o.rsvd", {25'h0, w.status_view.rsvd}, 32'h0);
        check_value("rd_dat_o.valid", {31'h0, w.status_view.valid}, {31'h0, valid});
    endtask

    task automatic check_zero(input int adr);
        logic [31:0] raw;
        host_read(adr, raw);
        check_value($sformatf("rd_dat_o (adr %0d)", adr), raw, 32'h0);
    endtask

    task automatic test_begin();
        errors_at_start = errors;
    endtask

    task automatic test_end(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_bad++;
            $display("test %s: FAIL, %0d errors", name, errors - errors_at_start);
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge ifclk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0]            latched;
        logic [`SCAL_CNT_W-1:0] exp_open;
        int                     a;

        rst_n_i  = 1'b0;
        count_i  = '0;
        timer_i  = 1'b0;
        rd_req_i = 1'b0;
        rd_adr_i = '0;
        void'($urandom(24));
        repeat (10) @(negedge ifclk);
        rst_n_i = 1'b1;

        test_begin();
        check_value("done_o", {31'h0, done_o}, 32'h0);
        check_value("rd_ack_o", {31'h0, rd_ack_o}, 32'h0);
        check_status(16'd0, 1'b0);
        for (int i = 0; i < NCNT; i++) begin
            check_count(i, '0);
        end
        test_end("reset_state");

        test_begin();
        drive_random(300);
        pulse_timer();
        check_all_counts();
        test_end("cycle_counting");

        test_begin();
        drive_random(200);          // fresh pattern for the second period
        pulse_timer();
        check_all_counts();
        check_status(16'd2, 1'b1);
        test_end("period_separation");

        test_begin();
        hold_bit(SAT_BIT, SAT_CYCLES);
        pulse_timer();
        check_count(SAT_BIT, {`SCAL_CNT_W{1'b1}});
        check_all_counts();         // neighbours keep their own counts
        test_end("saturation");

        test_begin();
        repeat (20) @(negedge ifclk);   // idle port, ack has to stay low
        for (int i = 0; i < 8; i++) begin
            a = $urandom_range(0, NCNT - 1);
            check_count(a, m_held[a]);
        end
        check_zero(NCNT);
        check_zero(64);
        check_zero(126);
        check_status(16'd3, 1'b1);
        test_end("handshake_rules");

        test_begin();
        pulse_timer();
        repeat (3) @(negedge ifclk);
        pulse_timer();
        pulse_timer();
        drive_random(100);
        exp_open = m_held[3];
        read_open(3, latched);
        check_value("rd_dat_o.count (adr 3)", latched, {16'h0, exp_open});
        pulse_timer();              // snapshot while the read is open
        repeat (4) @(negedge ifclk);
        check_value("rd_dat_o across snapshot", rd_dat_o, {16'h0, exp_open});
        read_close(2);
        check_count(3, m_held[3]);
        check_status(16'd7, 1'b1);
        test_end("done_timing");

        $display("summary: %0d tests, %0d failing, %0d value checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/scaler_pkg.sv
hw/beam_scaler_bank.sv
hw/scaler_readout.sv
hw/beamscaler_top.sv
dv/beamscaler_tb.sv

// ==== Makefile ====
# Verilator build and run of the beam scaler testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= beamscaler_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# build, run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@$(SIM_BIN) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)
